/* src.f */
predecPkg.sv
predecBoundary.sv
predecClass.sv
predecCompact.sv
predecTop.sv
tbPredec.sv

/* run.sh */
#!/bin/sh
# Compile and run the predecoder testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f src.f --top-module tbPredec
./obj_dir/VtbPredec | tee sim.log
if grep -q "Simulation failed" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"

/* tbPredec.sv */
`timescale 1ns/1ns

module tbPredec;
  import predecPkg::*;

  logic                clk;
  logic                arstN;
  logic                bundleValid;
  logic [255:0]        bundle;
  logic [offW-1:0]     startOff;
  logic                outValid;
  slotT                slots [maxSlots];
  logic [maxSlots-1:0] instrEn;
  slotT                jumps [maxJumps];
  logic [maxJumps-1:0] jumpEn;
  logic                hasJumps;
  logic                error;
  logic                jerror;
  logic                isAvx;

  int          errors;
  int          timeouts;

  slotT                expSlots [maxSlots];       // Reference model results.
  logic [maxSlots-1:0] expInstrEn;
  slotT                expJumps [maxJumps];
  logic [maxJumps-1:0] expJumpEn;
  logic                expHasJumps;
  logic                expError;
  logic                expJerror;

  predecTop u_dut (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic checkSlot(input slotT got, input slotT want, input string name);
    if (got !== want) begin
      errors++;
      $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic checkCls(input clsT got, input clsT want, input string name);
    if (got !== want) begin
      errors++;
      $display("** Error at %0t ns: %s got %b expected %b", $time, name, got, want);
    end
  endtask

  task automatic checkBit(input logic got, input logic want, input string name);
    if (got !== want) begin
      errors++;
      $display("** Error at %0t ns: %s got %b expected %b", $time, name, got, want);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model.
  ////////////////////////////////////////////////////////////

  function automatic clsT refClass(input parcelT head, input int len);
    clsT c;
    int  op;
    int  sub;
    c   = '0;
    op  = int'(head[7:0]);
    sub = op % 64;
    if (len == 1) begin
      if (sub <= 31) begin
        c.alu   = sub <= 15;
        c.shift = sub >= 16;
      end else if (sub >= 48 && sub <= 51) begin
        c.jump = 1'b1;
        c.alu  = 1'b1;
      end
    end else if (op <= 39) begin
      c.alu = !head[2];
      c.mul = head[2];
    end else if (op <= 45) begin
      c.shift = 1'b1;
    end else if (op >= 64 && op <= 127) begin
      c.load  = !head[0];
      c.store = head[0];
    end else if ((op >= 160 && op <= 175) || op == 178 || op == 179) begin
      c.jump = 1'b1;
      c.alu  = 1'b1;
    end else if (op == 180 || op == 181) begin
      c.jump = 1'b1;
    end else if (op == 182) begin
      c.jump  = 1'b1;
      c.indir = 1'b1;
    end else if (op == 255) begin
      c.sys   = 1'b1;
      c.jump  = !head[15];                        // Bit 15 clear redirects fetch.
      c.indir = !head[15];
    end
    return c;
  endfunction

  task automatic runModel(input logic [255:0] b, input logic [offW-1:0] so);
    slotT item;
    logic startK;
    int   len;
    int   n;
    int   nj;
    n          = 0;
    nj         = 0;
    expInstrEn = '0;
    expJumpEn  = '0;
    for (int i = 0; i < maxSlots; i++) expSlots[i] = '0;
    for (int i = 0; i < maxJumps; i++) expJumps[i] = '0;
    expError = int'(so) > nParcels - 1;
    for (int k = 0; k < nParcels; k++) begin
      startK = (k == 0) ? 1'b1 : b[239+k];
      len    = 0;
      for (int j = maxLen - 1; j >= 0; j--) begin
        if (k + j < nParcels && b[240+k+j]) len = j + 1;
      end
      if (startK && k >= int'(so)) begin
        if (len == 0) begin
          expError = 1'b1;
        end else begin
          item = '0;
          for (int j = 0; j < maxLen; j++) begin
            if (k + j < nParcels) item.instr[j*parcelW +: parcelW] = b[(k+j)*parcelW +: parcelW];
          end
          item.cls = refClass(b[k*parcelW +: parcelW], len);
          item.off = offW'(k);
          item.len = lenW'(len);
          if (n < maxSlots) begin
            expSlots[n]   = item;
            expInstrEn[n] = 1'b1;
          end
          n++;
          if (item.cls.jump) begin
            if (nj < maxJumps) begin
              expJumps[nj]  = item;
              expJumpEn[nj] = 1'b1;
            end
            nj++;
          end
        end
      end
    end
    expError    = expError || n > maxSlots;
    expJerror   = nj > maxJumps;
    expHasJumps = nj > 0;
  endtask

  task automatic checkOutputs(input logic avx);
    for (int i = 0; i < maxSlots; i++) begin
      checkSlot(slots[i], expSlots[i], $sformatf("slots[%0d]", i));
      checkBit(instrEn[i], expInstrEn[i], $sformatf("instrEn[%0d]", i));
    end
    for (int i = 0; i < maxJumps; i++) begin
      checkSlot(jumps[i], expJumps[i], $sformatf("jumps[%0d]", i));
      checkBit(jumpEn[i], expJumpEn[i], $sformatf("jumpEn[%0d]", i));
    end
    checkBit(hasJumps, expHasJumps, "hasJumps");
    checkBit(error, expError, "error");
    checkBit(jerror, expJerror, "jerror");
    checkBit(isAvx, avx, "isAvx");
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus.
  ////////////////////////////////////////////////////////////

  function automatic logic [239:0] randomText();
    logic [255:0] r;
    for (int i = 0; i < 8; i++) r[i*32 +: 32] = $urandom;
    return r[239:0];
  endfunction

  task automatic sendBundle(input logic [255:0] b, input logic [offW-1:0] so);
    int waited;
    runModel(b, so);
    @(posedge clk);
    #1;
    bundle      = b;
    startOff    = so;
    bundleValid = 1'b1;
    @(posedge clk);
    #1;
    bundleValid = 1'b0;
    waited      = 0;
    while (!outValid && waited < 10) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!outValid) begin
      timeouts++;
      $display("Timeout: outValid did not rise within 10 cycles of the strobe");
    end else begin
      if (waited != 0) begin
        errors++;
        $display("Outputs arrived %0d cycles later than one cycle after the strobe", waited);
      end
      checkOutputs(b[255]);
      @(posedge clk);
      #1;
      checkBit(outValid, 1'b0, "outValid");   // The strobe lasts one cycle.
    end
  endtask

  task automatic testReset();
    checkBit(outValid, 1'b0, "outValid");
    checkBit(|instrEn, 1'b0, "instrEn");
    checkBit(|jumpEn, 1'b0, "jumpEn");
    checkBit(hasJumps, 1'b0, "hasJumps");
    checkBit(error, 1'b0, "error");
    checkBit(jerror, 1'b0, "jerror");
    repeat (5) begin
      @(posedge clk);
      #1;
      checkBit(outValid, 1'b0, "outValid");
    end
  endtask

  task automatic testPacking();
    logic [255:0] b;
    b = {1'b1, 15'b101_0110_0010_0101, randomText()}; // Lengths 1 2 3 4 1 2 2.
    sendBundle(b, 4'd0);
    checkBit(instrEn == 8'h7f, 1'b1, "instrEn all seven");
    sendBundle(b, 4'd3);
    checkBit(slots[0].off == 4'd3, 1'b1, "slots[0].off");
  endtask

  task automatic testClass(input parcelT head, input int len, input clsT want);
    logic [255:0] b;
    b = {1'b0, 15'd0, randomText()};
    b[15:0] = head;
    for (int k = len - 1; k < nParcels; k++) b[240+k] = 1'b1; // Rest are one-parcel.
    sendBundle(b, 4'd0);
    checkCls(slots[0].cls, want, $sformatf("cls of %h len %0d", head, len));
  endtask

  task automatic testJumps();
    logic [255:0] b;
    b = {1'b0, 15'b101_1010_1010_1010, randomText()}; // Starts 0 2 4 6 8 10 12 13.
    for (int k = 0; k < nParcels; k++) b[k*parcelW +: 8] = 8'h50;
    b[0*parcelW +: 8]  = 8'hb4;
    b[4*parcelW +: 8]  = 8'ha5;
    b[10*parcelW +: 8] = 8'hb6;
    sendBundle(b, 4'd0);
    checkBit(hasJumps, 1'b1, "hasJumps");
    checkBit(jumpEn == 4'b0111, 1'b1, "jumpEn three");
    b[6*parcelW +: 8]  = 8'hb5;
    b[12*parcelW +: 8] = 8'h30;                   // Short-form jump.
    sendBundle(b, 4'd0);
    checkBit(jerror, 1'b1, "jerror");
    checkBit(jumps[3].off == 4'd10, 1'b1, "jumps[3].off");
  endtask

  task automatic testErrors();
    sendBundle({1'b0, 15'b101_0101_1111_1111, randomText()}, 4'd0);
    checkBit(error, 1'b1, "error on too many starts");
    sendBundle({1'b0, 15'b101_0110_0010_0101, randomText()}, 4'd15);
    checkBit(error, 1'b1, "error on startOff 15");
    sendBundle({1'b0, 15'b101_0101_0100_0001, randomText()}, 4'd0);
    checkBit(error, 1'b1, "error on long gap");
  endtask

  task automatic testBackToBack();
    logic [255:0]    b;
    logic [255:0]    prevB;
    logic [offW-1:0] prevSo;
    logic [14:0]     ends;
    int              pos;
    int              len;
    @(posedge clk);
    #1;
    for (int n = 0; n <= 20; n++) begin
      if (n > 0) begin
        runModel(prevB, prevSo);
        checkBit(outValid, 1'b1, "outValid");
        checkOutputs(prevB[255]);
      end
      if (n < 20) begin
        ends = '0;
        pos  = 0;
        while (pos < nParcels) begin
          len = 1 + int'($urandom % 4);
          pos = pos + len;
          if (pos <= nParcels) ends[pos-1] = 1'b1;
        end
        if ($urandom % 4 == 0) ends = 15'($urandom);  // Occasionally malformed.
        b           = {1'($urandom), ends, randomText()};
        prevB       = b;
        prevSo      = offW'($urandom % 6);
        bundle      = b;
        startOff    = prevSo;
        bundleValid = 1'b1;
      end else begin
        bundleValid = 1'b0;
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    errors      = 0;
    timeouts    = 0;
    void'($urandom(32'ha910));
    arstN       = 1'b0;
    bundleValid = 1'b0;
    bundle      = '0;
    startOff    = '0;
    repeat (3) @(posedge clk);
    #1;
    arstN = 1'b1;
    testReset();
    testPacking();
    testClass(16'h0005, 1, 8'b0010_0000);         // Flag order is jump indir alu shift mul ld st sys.
    testClass(16'h0014, 1, 8'b0001_0000);
    testClass(16'h00d1, 1, 8'b0001_0000);
    testClass(16'h0031, 1, 8'b1010_0000);
    testClass(16'h0028, 1, 8'b0000_0000);
    testClass(16'h0003, 2, 8'b0010_0000);
    testClass(16'h0024, 2, 8'b0000_1000);
    testClass(16'h002a, 3, 8'b0001_0000);
    testClass(16'h0040, 2, 8'b0000_0100);
    testClass(16'h0045, 4, 8'b0000_0010);
    testClass(16'h00a5, 2, 8'b1010_0000);
    testClass(16'h00b2, 2, 8'b1010_0000);
    testClass(16'h00b3, 3, 8'b1010_0000);
    testClass(16'h00b4, 2, 8'b1000_0000);
    testClass(16'h00b5, 4, 8'b1000_0000);
    testClass(16'h00b6, 2, 8'b1100_0000);
    testClass(16'h00ff, 2, 8'b1100_0001);
    testClass(16'h80ff, 2, 8'b0000_0001);
    testClass(16'h00c8, 2, 8'b0000_0000);
    testJumps();
    testErrors();
    testBackToBack();
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #200000;
    $display("Run did not finish in time. Errors: %0d, timeouts: %0d", errors, timeouts);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* predecTop.sv */
`timescale 1ns/1ns

module predecTop (
  input  logic                                clk,
  input  logic                                arstN,
  input  logic                                bundleValid,
  input  logic [255:0]                        bundle,
  input  logic [predecPkg::offW-1:0]          startOff,
  output logic                                outValid,
  output predecPkg::slotT                     slots [predecPkg::maxSlots],
  output logic [predecPkg::maxSlots-1:0]      instrEn,
  output predecPkg::slotT                     jumps [predecPkg::maxJumps],
  output logic [predecPkg::maxJumps-1:0]      jumpEn,
  output logic                                hasJumps,
  output logic                                error,
  output logic                                jerror,
  output logic                                isAvx
);
  import predecPkg::*;

  logic [(nParcels+maxLen-1)*parcelW-1:0] textExt;
  logic [nParcels-1:0]                    endBits;
  logic [nParcels-1:0]                    startMask;
  logic [lenW-1:0]                        lenOf [nParcels];
  logic                                   boundaryErr;
  clsT                                    clsOf [nParcels];
  slotT                                   items [nParcels];
  logic [nParcels-1:0]                    jumpSel;
  slotT                                   instrSlots [maxSlots];
  logic [maxSlots-1:0]                    instrValid;
  slotT                                   jumpSlots [maxJumps];
  logic [maxJumps-1:0]                    jumpValid;
  logic                                   jumpOverflow;

  assign endBits = bundle[nParcels*parcelW +: nParcels];
  assign textExt = {{((maxLen-1)*parcelW){1'b0}}, bundle[nParcels*parcelW-1:0]};

  predecBoundary uBoundary (
    .endBits   (endBits),
    .startOff  (startOff),
    .startMask (startMask),
    .lenOf     (lenOf),
    .error     (boundaryErr)
  );

  ////////////////////////////////////////////////////////////
  // Per-parcel classification.
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < nParcels; k++) begin : gParcel
    predecClass uClass (
      .head (parcelT'(bundle[k*parcelW +: parcelW])),
      .len  (lenOf[k]),
      .cls  (clsOf[k])
    );

    assign items[k] = '{instr: textExt[k*parcelW +: maxLen*parcelW], cls: clsOf[k],
                        off: offW'(k), len: lenOf[k]};
    assign jumpSel[k] = startMask[k] & clsOf[k].jump;
  end

  predecCompact #(.nSlots(maxSlots)) instrCompact (
    .sel      (startMask),
    .items    (items),
    .slots    (instrSlots),
    .en       (instrValid),
    .overflow ()                                  // Boundary logic already flags this.
  );

  predecCompact #(.nSlots(maxJumps)) jumpCompact (
    .sel      (jumpSel),
    .items    (items),
    .slots    (jumpSlots),
    .en       (jumpValid),
    .overflow (jumpOverflow)
  );

  ////////////////////////////////////////////////////////////
  // Output register.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
      instrEn  <= '0;
      jumpEn   <= '0;
      hasJumps <= 1'b0;
      error    <= 1'b0;
      jerror   <= 1'b0;
    end else begin
      outValid <= bundleValid;                    // One strobe per accepted bundle.
      if (bundleValid) begin
        instrEn  <= instrValid;
        jumpEn   <= jumpValid;
        hasJumps <= |jumpSel;
        error    <= boundaryErr;
        jerror   <= jumpOverflow;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bundleValid) begin
      slots <= instrSlots;
      jumps <= jumpSlots;
      isAvx <= bundle[255];                       // AVX mode passes straight through.
    end
  end

endmodule

/* predecCompact.sv */
`timescale 1ns/1ns

module predecCompact #(
  parameter int nSlots = predecPkg::maxSlots
) (
  input  logic [predecPkg::nParcels-1:0] sel,
  input  predecPkg::slotT                items [predecPkg::nParcels],
  output predecPkg::slotT                slots [nSlots],
  output logic [nSlots-1:0]              en,
  output logic                           overflow
);
  import predecPkg::*;

  logic [offW-1:0] prefix [nParcels];
  logic [offW-1:0] total;

  ////////////////////////////////////////////////////////////
  // Running count of selected parcels.
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic [offW-1:0] run;
    run = '0;
    for (int k = 0; k < nParcels; k++) begin
      run       = run + offW'(sel[k]);
      prefix[k] = run;                            // Count of selected parcels 0 to k.
    end
  end

  assign total = prefix[nParcels-1];

  ////////////////////////////////////////////////////////////
  // Slot routing.
  ////////////////////////////////////////////////////////////

  // Each item lands in at most one slot, so an AND-OR mux is enough.
  always_comb begin
    for (int i = 0; i < nSlots; i++) begin
      slots[i] = '0;
      for (int k = 0; k < nParcels; k++) begin
        if (sel[k] && prefix[k] == offW'(i + 1)) begin
          slots[i] = slots[i] | items[k];
        end
      end
      en[i] = total > offW'(i);
    end
  end

  assign overflow = total > nSlots;               // Excess items are dropped.

endmodule

/* predecClass.sv */
`timescale 1ns/1ns

module predecClass (
  input  predecPkg::parcelT          head,
  input  logic [predecPkg::lenW-1:0] len,
  output predecPkg::clsT             cls
);
  import predecPkg::*;

  logic [7:0] op;
  logic [5:0] sub;
  logic [5:0] subBase;
  clsT        shortCls;
  clsT        longCls;

  assign op      = head[7:0];
  assign sub     = op[5:0];
  assign subBase = {sub[5:4], 4'b0000};           // Base of the 16-entry group.

  ////////////////////////////////////////////////////////////
  // Short form, one parcel.
  ////////////////////////////////////////////////////////////

  always_comb begin
    shortCls       = '0;
    shortCls.alu   = subBase == subAluLo;
    shortCls.shift = subBase == subShiftLo;
    if (sub >= subJmpLo && sub <= subJmpHi) begin
      shortCls.jump = 1'b1;                       // Compact conditional jumps.
      shortCls.alu  = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Long form, two to four parcels.
  ////////////////////////////////////////////////////////////

  always_comb begin
    longCls = '0;
    if (op < 8'd40) begin
      longCls.alu = ~op[2];                       // Bit 2 selects the multiplier.
      longCls.mul = op[2];
    end
    if (op >= 8'd40 && op <= 8'd45) begin
      longCls.shift = 1'b1;
    end
    if (op[7:6] == 2'b01) begin
      longCls.load  = ~op[0];                     // Odd opcodes in 64 to 127 store.
      longCls.store = op[0];
    end
    if (op[7:4] == 4'b1010) begin
      longCls.jump = 1'b1;
      longCls.alu  = 1'b1;
    end
    case (op)
      opSelfJmpA,
      opSelfJmpB: begin
        longCls.jump = 1'b1;
        longCls.alu  = 1'b1;
      end
      opLongJmp,
      opUncondJmp: begin
        longCls.jump = 1'b1;
      end
      opIndirJmp: begin
        longCls.jump  = 1'b1;
        longCls.indir = 1'b1;
      end
      opSys: begin
        longCls.sys   = 1'b1;
        longCls.jump  = ~head[15];                // System calls redirect fetch.
        longCls.indir = ~head[15];
      end
      default: ;
    endcase
  end

  assign cls = (len == lenW'(1)) ? shortCls : longCls;

endmodule

/* predecBoundary.sv */
`timescale 1ns/1ns

module predecBoundary (
  input  logic [predecPkg::nParcels-1:0] endBits,
  input  logic [predecPkg::offW-1:0]     startOff,
  output logic [predecPkg::nParcels-1:0] startMask,
  output logic [predecPkg::lenW-1:0]     lenOf [predecPkg::nParcels],
  output logic                           error
);
  import predecPkg::*;

  logic [nParcels-1:0]          isStart;
  logic [nParcels-1:0]          hasEnd;
  logic [nParcels-1:0]          inRange;
  logic [nParcels+maxLen-2:0]   endExt;
  logic [offW-1:0]              nStarts;
  logic                         badLen;

  // Parcel 0 always starts an instruction and every other start follows an end bit.
  assign isStart = {endBits[nParcels-2:0], 1'b1};
  assign endExt  = {{(maxLen-1){1'b0}}, endBits}; // Ends past the bundle never match.

  always_comb begin
    for (int k = 0; k < nParcels; k++) begin
      lenOf[k]  = '0;
      hasEnd[k] = 1'b0;
      for (int j = maxLen - 1; j >= 0; j--) begin
        if (endExt[k+j]) begin                    // The nearest end bit wins.
          lenOf[k]  = lenW'(j + 1);
          hasEnd[k] = 1'b1;
        end
      end
      inRange[k] = k >= int'(startOff);
    end
  end

  assign startMask = isStart & hasEnd & inRange;
  assign badLen    = |(isStart & ~hasEnd & inRange);

  always_comb begin
    nStarts = '0;
    for (int k = 0; k < nParcels; k++) begin
      nStarts = nStarts + offW'(startMask[k]);
    end
  end

  ////////////////////////////////////////////////////////////
  // Bundle errors.
  ////////////////////////////////////////////////////////////

  always_comb begin
    error = 1'b0;
    if (nStarts > maxSlots) begin
      error = 1'b1;                               // More instructions than output slots.
    end
    if (startOff >= nParcels) begin
      error = 1'b1;
    end
    if (badLen) begin
      error = 1'b1;                               // An instruction runs past four parcels.
    end
  end

endmodule

/* predecPkg.sv */
package predecPkg;

  ////////////////////////////////////////////////////////////
  // Bundle geometry and slot counts.
  ////////////////////////////////////////////////////////////

  localparam int parcelW  = 16;
  localparam int nParcels = 15;                  // Parcels carried in one fetch bundle.
  localparam int maxLen   = 4;                   // Longest legal instruction, in parcels.
  localparam int maxSlots = 8;
  localparam int maxJumps = 4;
  localparam int offW     = 4;
  localparam int lenW     = 3;

  typedef logic [parcelW-1:0] parcelT;

  // Text of one instruction, starting with its first parcel.
  typedef logic [maxLen*parcelW-1:0] instrT;

  ////////////////////////////////////////////////////////////
  // Opcodes.
  ////////////////////////////////////////////////////////////

  // Long-form opcodes that the class table names one by one.
  typedef enum logic [7:0] {
    opSelfJmpA  = 8'd178,
    opSelfJmpB  = 8'd179,
    opLongJmp   = 8'd180,
    opUncondJmp = 8'd181,
    opIndirJmp  = 8'd182,
    opSys       = 8'd255
  } mainOpE;

  // Lower bounds of the short-form groups.
  typedef enum logic [5:0] {
    subAluLo   = 6'd0,
    subShiftLo = 6'd16,
    subJmpLo   = 6'd48,
    subJmpHi   = 6'd51
  } subOpE;

  ////////////////////////////////////////////////////////////
  // Class flags and output slots.
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic jump;
    logic indir;
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic sys;
  } clsT;

  typedef struct packed {
    instrT             instr;
    clsT               cls;
    logic [offW-1:0]   off;                      // Parcel index of the first parcel.
    logic [lenW-1:0]   len;
  } slotT;

endpackage
